//--- logic/conv_pkg.sv
package conv_pkg;

	////////////////////////////////////////////////////////////
	// word and kernel geometry
	////////////////////////////////////////////////////////////

	localparam int DATA_WIDTH      = 16;
	localparam int KERNEL_SIZE     = 3;
	localparam int KERNEL_TAPS     = KERNEL_SIZE * KERNEL_SIZE;
	localparam int HOST_ADDR_WIDTH = 12;  // host bus address.
	localparam int BIAS_DEPTH      = 2;   // bias words per unit.

	// signed two's-complement word, wraps on overflow.
	typedef logic signed [DATA_WIDTH-1:0] data_t;

	// tap index is row * KERNEL_SIZE + column, tap 0 is the oldest pixel.
	typedef data_t [KERNEL_TAPS-1:0] window_t;

	////////////////////////////////////////////////////////////
	// strobes and host port
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic conv_enable;     // product stage.
		logic accu_enable;     // partial-sum stage.
		logic relu_enable;     // bias and relu stage.
		logic wm_fifo_enable;  // kernel register shift.
	} unit_ctrl_t;

	typedef struct packed {
		data_t                      data;
		logic [HOST_ADDR_WIDTH-1:0] address;
	} host_write_t;

endpackage

//--- logic/window_buffer.sv
`timescale 1ns/1ps

module window_buffer #(
	parameter int IFM_SIZE = 6
)(
	input  logic               clk,
	input  logic               arst_n,
	input  logic               fifo_enable,
	input  conv_pkg::data_t    pixel,
	output conv_pkg::window_t  window
);

	import conv_pkg::*;

	// enough history to reach the oldest corner of the window.
	localparam int CHAIN_LEN = (KERNEL_SIZE - 1) * IFM_SIZE + KERNEL_SIZE;

	data_t chain [CHAIN_LEN];  // chain[0] is the newest pixel.

	////////////////////////////////////////////////////////////
	// shift chain
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < CHAIN_LEN; i++) begin
				chain[i] <= '0;
			end
		end else if (fifo_enable) begin
			chain[0] <= pixel;
			for (int i = 1; i < CHAIN_LEN; i++) begin
				chain[i] <= chain[i-1];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// window taps
	////////////////////////////////////////////////////////////

	// rows sit IFM_SIZE apart in the chain, columns one apart.
	for (genvar r = 0; r < KERNEL_SIZE; r++) begin : g_row
		for (genvar c = 0; c < KERNEL_SIZE; c++) begin : g_col
			localparam int DEPTH = (KERNEL_SIZE - 1 - r) * IFM_SIZE + (KERNEL_SIZE - 1 - c);
			assign window[r*KERNEL_SIZE + c] = chain[DEPTH];
		end
	end

endmodule

//--- logic/weight_memory.sv
`timescale 1ns/1ps

module weight_memory #(
	parameter int IFM_DEPTH = 2
)(
	input  logic                                                clk,
	input  logic                                                arst_n,
	input  logic                                                enable_write,
	input  logic                                                enable_read,
	input  logic [$clog2(conv_pkg::KERNEL_TAPS*IFM_DEPTH)-1:0] address,
	input  conv_pkg::data_t                                     data_in,
	output conv_pkg::data_t                                     data_out
);

	import conv_pkg::*;

	// one kernel per input channel.
	localparam int DEPTH = KERNEL_TAPS * IFM_DEPTH;

	data_t mem [DEPTH];

	// host write port.
	always_ff @(posedge clk) begin
		if (enable_write) begin
			mem[address] <= data_in;
		end
	end

	// registered read, holds while enable_read is low.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_out <= '0;
		end else if (enable_read) begin
			data_out <= mem[address];  // old word on read-during-write.
		end
	end

endmodule

//--- logic/bias_memory.sv
`timescale 1ns/1ps

module bias_memory #(
	parameter int NUMBER_OF_UNITS = 2
)(
	input  logic                                      clk,
	input  logic                                      arst_n,
	input  logic [NUMBER_OF_UNITS-1:0]                enable_write,
	input  logic                                      enable_read,
	input  logic [$clog2(conv_pkg::BIAS_DEPTH)-1:0]   address,
	input  conv_pkg::data_t                           data_in,
	output conv_pkg::data_t                           bias [NUMBER_OF_UNITS]
);

	import conv_pkg::*;

	data_t mem [NUMBER_OF_UNITS][BIAS_DEPTH];  // one bank per unit.

	always_ff @(posedge clk) begin
		for (int u = 0; u < NUMBER_OF_UNITS; u++) begin
			if (enable_write[u]) begin
				mem[u][address] <= data_in;
			end
		end
	end

	// every bank reads the same address in the same cycle.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int u = 0; u < NUMBER_OF_UNITS; u++) begin
				bias[u] <= '0;
			end
		end else if (enable_read) begin
			for (int u = 0; u < NUMBER_OF_UNITS; u++) begin
				bias[u] <= mem[u][address];
			end
		end
	end

endmodule

//--- logic/conv_unit.sv
`timescale 1ns/1ps

module conv_unit #(
	parameter int IFM_DEPTH = 2
)(
	input  logic                                                clk,
	input  logic                                                arst_n,
	input  conv_pkg::window_t                                   window,
	input  conv_pkg::unit_ctrl_t                                ctrl,
	input  conv_pkg::data_t                                     host_data,
	input  logic                                                wm_enable_write,
	input  logic                                                wm_enable_read,
	input  logic [$clog2(conv_pkg::KERNEL_TAPS*IFM_DEPTH)-1:0] wm_address,
	input  conv_pkg::data_t                                     bias,
	input  conv_pkg::data_t                                     data_in_from_next,
	output conv_pkg::data_t                                     data_out_for_next
);

	import conv_pkg::*;

	data_t   wm_data;
	window_t kernel;
	data_t   dot;         // combinational dot product.
	data_t   prod_q;
	data_t   accu_q;
	data_t   biased_sum;
	data_t   out_q;

	////////////////////////////////////////////////////////////
	// weight store and kernel register
	////////////////////////////////////////////////////////////

	weight_memory #(
		.IFM_DEPTH(IFM_DEPTH)
	) wm (
		.clk(clk),
		.arst_n(arst_n),
		.enable_write(wm_enable_write),
		.enable_read(wm_enable_read),
		.address(wm_address),
		.data_in(host_data),
		.data_out(wm_data)
	);

	// newest weight enters the top tap, older ones slide toward tap 0.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			kernel <= '0;
		end else if (ctrl.wm_fifo_enable) begin
			kernel <= {wm_data, kernel[KERNEL_TAPS-1:1]};
		end
	end

	////////////////////////////////////////////////////////////
	// compute pipeline
	////////////////////////////////////////////////////////////

	always_comb begin
		dot = '0;
		for (int i = 0; i < KERNEL_TAPS; i++) begin
			dot = dot + window[i] * kernel[i];  // wraps at DATA_WIDTH.
		end
	end

	assign biased_sum = accu_q + bias;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prod_q <= '0;
		end else if (ctrl.conv_enable) begin
			prod_q <= dot;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			accu_q <= '0;
		end else if (ctrl.accu_enable) begin
			accu_q <= prod_q + data_in_from_next;  // partial sum from neighbour.
		end
	end

	// relu clips negative sums to zero.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_q <= '0;
		end else if (ctrl.relu_enable) begin
			out_q <= (biased_sum < 0) ? '0 : biased_sum;
		end
	end

	assign data_out_for_next = out_q;

endmodule

//--- logic/conv_datapath.sv
`timescale 1ns/1ps

module conv_datapath #(
	parameter int IFM_SIZE        = 6,
	parameter int IFM_DEPTH       = 2,
	parameter int NUMBER_OF_UNITS = 2
)(
	input  logic                                                clk,
	input  logic                                                arst_n,
	input  conv_pkg::host_write_t                               host,
	input  logic                                                wm_addr_sel,
	input  logic                                                wm_enable_read,
	input  logic [NUMBER_OF_UNITS-1:0]                          wm_enable_write,
	input  logic [$clog2(conv_pkg::KERNEL_TAPS*IFM_DEPTH)-1:0] wm_address_read_current,
	input  logic                                                bm_addr_sel,
	input  logic                                                bm_enable_read,
	input  logic [NUMBER_OF_UNITS-1:0]                          bm_enable_write,
	input  logic [$clog2(conv_pkg::BIAS_DEPTH)-1:0]             bm_address_read_current,
	input  logic                                                fifo_enable,
	input  conv_pkg::data_t                                     data_in_from_previous,
	input  conv_pkg::unit_ctrl_t                                ctrl,
	input  conv_pkg::data_t                                     data_in_from_next [NUMBER_OF_UNITS],
	output conv_pkg::data_t                                     data_out_for_next [NUMBER_OF_UNITS]
);

	import conv_pkg::*;

	localparam int WM_ADDR_WIDTH = $clog2(KERNEL_TAPS * IFM_DEPTH);
	localparam int BM_ADDR_WIDTH = $clog2(BIAS_DEPTH);

	logic [WM_ADDR_WIDTH-1:0] wm_address;
	logic [BM_ADDR_WIDTH-1:0] bm_address;
	window_t                  window;
	data_t                    bias [NUMBER_OF_UNITS];

	////////////////////////////////////////////////////////////
	// address select, host or controller
	////////////////////////////////////////////////////////////

	assign wm_address = wm_addr_sel ? wm_address_read_current : host.address[WM_ADDR_WIDTH-1:0];
	assign bm_address = bm_addr_sel ? bm_address_read_current : host.address[BM_ADDR_WIDTH-1:0];

	////////////////////////////////////////////////////////////
	// shared blocks
	////////////////////////////////////////////////////////////

	window_buffer #(
		.IFM_SIZE(IFM_SIZE)
	) line_buf (
		.clk(clk),
		.arst_n(arst_n),
		.fifo_enable(fifo_enable),
		.pixel(data_in_from_previous),
		.window(window)
	);

	bias_memory #(
		.NUMBER_OF_UNITS(NUMBER_OF_UNITS)
	) bm (
		.clk(clk),
		.arst_n(arst_n),
		.enable_write(bm_enable_write),
		.enable_read(bm_enable_read),
		.address(bm_address),
		.data_in(host.data),
		.bias(bias)
	);

	// one unit per output filter.
	for (genvar u = 0; u < NUMBER_OF_UNITS; u++) begin : g_unit
		conv_unit #(
			.IFM_DEPTH(IFM_DEPTH)
		) unit (
			.clk(clk),
			.arst_n(arst_n),
			.window(window),
			.ctrl(ctrl),
			.host_data(host.data),
			.wm_enable_write(wm_enable_write[u]),
			.wm_enable_read(wm_enable_read),
			.wm_address(wm_address),
			.bias(bias[u]),
			.data_in_from_next(data_in_from_next[u]),
			.data_out_for_next(data_out_for_next[u])
		);
	end

endmodule

//--- sim/conv_model.svh
////////////////////////////////////////////////////////////
// reference model of the layer datapath
////////////////////////////////////////////////////////////

data_t hist [CHAIN_LEN];               // hist[0] is the newest pixel.
data_t wmem [NUM_UNITS][WM_DEPTH];
data_t wm_rd [NUM_UNITS];
data_t bmem [NUM_UNITS][BIAS_DEPTH];
data_t bias_rd [NUM_UNITS];
data_t kern [NUM_UNITS][KERNEL_TAPS];
data_t prod [NUM_UNITS];
data_t accu [NUM_UNITS];
data_t outv [NUM_UNITS];
int    clip_count;                     // relu results forced to zero.
int    pass_count;

task automatic clear_model_state();
	for (int i = 0; i < CHAIN_LEN; i++) begin
		hist[i] = '0;
	end
	for (int u = 0; u < NUM_UNITS; u++) begin
		wm_rd[u] = '0;
		bias_rd[u] = '0;
		prod[u] = '0;
		accu[u] = '0;
		outv[u] = '0;
		for (int t = 0; t < KERNEL_TAPS; t++) begin
			kern[u][t] = '0;
		end
	end
	clip_count = 0;
	pass_count = 0;
endtask

// tap (r, c) entered (K-1-r) rows and (K-1-c) pixels before the newest one.
function automatic data_t expected_dot(input int u);
	int acc;
	int depth;
	acc = 0;
	for (int r = 0; r < KERNEL_SIZE; r++) begin
		for (int c = 0; c < KERNEL_SIZE; c++) begin
			depth = (KERNEL_SIZE - 1 - r) * IFM_SIZE + (KERNEL_SIZE - 1 - c);
			acc = acc + int'(hist[depth]) * int'(kern[u][r * KERNEL_SIZE + c]);
		end
	end
	return data_t'(acc);  // wraps at DATA_WIDTH.
endfunction

// one clock edge. later stages first, so each reads the value from before the edge.
task automatic advance_model();
	int    wa;
	int    ba;
	data_t sum;
	wa = wm_addr_sel ? int'(wm_address_read_current) : int'(host.address);
	ba = bm_addr_sel ? int'(bm_address_read_current) : int'(host.address);
	for (int u = 0; u < NUM_UNITS; u++) begin
		if (ctrl.relu_enable) begin
			sum = accu[u] + bias_rd[u];
			if (sum[DATA_WIDTH-1]) begin  // negative sum.
				outv[u] = '0;
				clip_count++;
			end else begin
				outv[u] = sum;
				pass_count++;
			end
		end
		if (ctrl.accu_enable) accu[u] = prod[u] + data_in_from_next[u];
		if (ctrl.conv_enable) prod[u] = expected_dot(u);
		if (ctrl.wm_fifo_enable) begin
			for (int t = 0; t < KERNEL_TAPS - 1; t++) begin
				kern[u][t] = kern[u][t+1];
			end
			kern[u][KERNEL_TAPS-1] = wm_rd[u];
		end
		if (wm_enable_read) wm_rd[u] = wmem[u][wa];
		if (wm_enable_write[u]) wmem[u][wa] = host.data;
		if (bm_enable_read) bias_rd[u] = bmem[u][ba];
		if (bm_enable_write[u]) bmem[u][ba] = host.data;
	end
	if (fifo_enable) begin
		for (int i = CHAIN_LEN - 1; i > 0; i--) begin
			hist[i] = hist[i-1];
		end
		hist[0] = data_in_from_previous;
	end
endtask

//--- sim/conv_datapath_tb.sv
`timescale 1ns/1ps

module conv_datapath_tb;

	import conv_pkg::*;

	localparam int IFM_SIZE     = 6;
	localparam int IFM_DEPTH    = 2;
	localparam int NUM_UNITS    = 2;
	localparam int CHAIN_LEN    = (KERNEL_SIZE - 1) * IFM_SIZE + KERNEL_SIZE;
	localparam int WM_DEPTH     = KERNEL_TAPS * IFM_DEPTH;
	localparam int WM_AW        = $clog2(WM_DEPTH);
	localparam int BM_AW        = $clog2(BIAS_DEPTH);
	localparam int MAP_PIXELS   = IFM_SIZE * IFM_SIZE;
	localparam int N_WINDOWS    = 6;   // random windows per kernel.
	localparam int CLK_PERIOD   = 20;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES  = 5;
	localparam int HOLD_CYCLES  = 8;
	localparam int SEED         = 10039;
	localparam int N_LOADS      = IFM_DEPTH;
	// upper bound on pixels pushed over the whole run.
	localparam int N_PIXELS     = N_LOADS * (CHAIN_LEN + 3 * N_WINDOWS) + MAP_PIXELS;
	localparam int WATCHDOG_CYCLES = (N_PIXELS + N_LOADS) * 40;

	logic                 clk = 1'b0;
	logic                 arst_n;
	host_write_t          host;
	logic                 wm_addr_sel;
	logic                 wm_enable_read;
	logic [NUM_UNITS-1:0] wm_enable_write;
	logic [WM_AW-1:0]     wm_address_read_current;
	logic                 bm_addr_sel;
	logic                 bm_enable_read;
	logic [NUM_UNITS-1:0] bm_enable_write;
	logic [BM_AW-1:0]     bm_address_read_current;
	logic                 fifo_enable;
	data_t                data_in_from_previous;
	unit_ctrl_t           ctrl;
	data_t                data_in_from_next [NUM_UNITS];
	data_t                data_out_for_next [NUM_UNITS];

	logic [31:0] rng_state;
	int          errors;
	int          checks;

	`include "conv_model.svh"

	conv_datapath UUT (
		.clk(clk),
		.arst_n(arst_n),
		.host(host),
		.wm_addr_sel(wm_addr_sel),
		.wm_enable_read(wm_enable_read),
		.wm_enable_write(wm_enable_write),
		.wm_address_read_current(wm_address_read_current),
		.bm_addr_sel(bm_addr_sel),
		.bm_enable_read(bm_enable_read),
		.bm_enable_write(bm_enable_write),
		.bm_address_read_current(bm_address_read_current),
		.fifo_enable(fifo_enable),
		.data_in_from_previous(data_in_from_previous),
		.ctrl(ctrl),
		.data_in_from_next(data_in_from_next),
		.data_out_for_next(data_out_for_next)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// random numbers and helpers
	////////////////////////////////////////////////////////////

	function automatic int next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return int'(rng_state[30:16]);
	endfunction

	function automatic int random_in(input int lo, input int hi);
		return lo + next_random() % (hi - lo + 1);
	endfunction

	task automatic clear_strobes();
		wm_enable_write = '0;
		bm_enable_write = '0;
		wm_enable_read = 1'b0;
		bm_enable_read = 1'b0;
		fifo_enable = 1'b0;
		ctrl = '0;
	endtask

	task automatic randomize_partial_sums();
		for (int u = 0; u < NUM_UNITS; u++) begin
			data_in_from_next[u] = data_t'(random_in(-200, 200));
		end
	endtask

	task automatic check_outputs();
		for (int u = 0; u < NUM_UNITS; u++) begin
			checks++;
			assert (data_out_for_next[u] === outv[u]) else begin
				errors++;
				$display("FAILED time %0t: data_out_for_next[%0d] expected %0d, got %0d",
					$time, u, outv[u], data_out_for_next[u]);
			end
		end
	endtask

	// model sees the inputs the DUT samples at the coming edge.
	task automatic clock_cycle();
		advance_model();
		@(posedge clk);
		#(DRIVE_DELAY);
		check_outputs();
	endtask

	task automatic write_weight(input int u, input int a);
		clear_strobes();
		wm_addr_sel = 1'b0;
		host.address = HOST_ADDR_WIDTH'(a);
		host.data = data_t'(random_in(-8, 7));
		wm_enable_write[u] = 1'b1;
		clock_cycle();
	endtask

	task automatic write_bias(input int u, input int a);
		clear_strobes();
		bm_addr_sel = 1'b0;
		host.address = HOST_ADDR_WIDTH'(a);
		host.data = data_t'(random_in(-300, 300));
		bm_enable_write[u] = 1'b1;
		clock_cycle();
	endtask

	task automatic read_bias(input int a);
		clear_strobes();
		bm_addr_sel = 1'b1;
		bm_address_read_current = BM_AW'(a);
		bm_enable_read = 1'b1;
		clock_cycle();
		clear_strobes();
	endtask

	// read data trails the address by one cycle, so the shift does too.
	task automatic load_kernel(input int base);
		clear_strobes();
		wm_addr_sel = 1'b1;
		for (int j = 0; j <= KERNEL_TAPS; j++) begin
			wm_enable_read = (j < KERNEL_TAPS);
			if (j < KERNEL_TAPS) wm_address_read_current = WM_AW'(base + j);
			ctrl.wm_fifo_enable = (j > 0);
			clock_cycle();
		end
		clear_strobes();
	endtask

	task automatic push_pixel();
		clear_strobes();
		data_in_from_previous = data_t'(random_in(-8, 7));
		fifo_enable = 1'b1;
		clock_cycle();
		clear_strobes();
	endtask

	task automatic run_window();
		clear_strobes();
		ctrl.conv_enable = 1'b1;
		clock_cycle();
		clear_strobes();
		randomize_partial_sums();
		ctrl.accu_enable = 1'b1;
		clock_cycle();
		clear_strobes();
		ctrl.relu_enable = 1'b1;
		clock_cycle();
		clear_strobes();
	endtask

	// one pixel per cycle with all three stages busy.
	task automatic stream_feature_map();
		logic conv_d;
		logic accu_d;
		conv_d = 1'b0;
		accu_d = 1'b0;
		for (int p = 0; p < MAP_PIXELS + 3; p++) begin
			clear_strobes();
			randomize_partial_sums();
			if (p < MAP_PIXELS) begin
				data_in_from_previous = data_t'(random_in(-8, 7));
				fifo_enable = 1'b1;
			end
			ctrl.conv_enable = (p >= CHAIN_LEN) && (p <= MAP_PIXELS);
			ctrl.accu_enable = conv_d;
			ctrl.relu_enable = accu_d;
			accu_d = ctrl.accu_enable;
			conv_d = ctrl.conv_enable;
			clock_cycle();
		end
		clear_strobes();
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		data_t held [NUM_UNITS];
		rng_state = SEED;
		errors = 0;
		checks = 0;
		arst_n = 1'b0;
		host = '0;
		wm_addr_sel = 1'b0;
		wm_address_read_current = '0;
		bm_addr_sel = 1'b0;
		bm_address_read_current = '0;
		data_in_from_previous = '0;
		for (int u = 0; u < NUM_UNITS; u++) begin
			data_in_from_next[u] = '0;
		end
		clear_strobes();
		clear_model_state();
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		arst_n = 1'b1;

		repeat (IDLE_CYCLES) clock_cycle();  // outputs stay cleared.

		for (int u = 0; u < NUM_UNITS; u++) begin
			for (int a = 0; a < WM_DEPTH; a++) write_weight(u, a);
			for (int a = 0; a < BIAS_DEPTH; a++) write_bias(u, a);
		end

		for (int ch = 0; ch < IFM_DEPTH; ch++) begin
			load_kernel(ch * KERNEL_TAPS);
			read_bias(ch % BIAS_DEPTH);
			repeat (CHAIN_LEN) push_pixel();
			for (int w = 0; w < N_WINDOWS; w++) begin
				repeat (random_in(1, 3)) push_pixel();
				run_window();
			end
		end

		stream_feature_map();

		// outputs must not move while only data inputs change.
		for (int u = 0; u < NUM_UNITS; u++) held[u] = outv[u];
		repeat (HOLD_CYCLES) begin
			host.data = data_t'(random_in(-300, 300));
			host.address = HOST_ADDR_WIDTH'(random_in(0, 4095));
			data_in_from_previous = data_t'(random_in(-8, 7));
			randomize_partial_sums();
			clock_cycle();
			for (int u = 0; u < NUM_UNITS; u++) begin
				assert (data_out_for_next[u] === held[u]) else begin
					errors++;
					$display("FAILED time %0t: data_out_for_next[%0d] expected %0d, got %0d",
						$time, u, held[u], data_out_for_next[u]);
				end
			end
		end

		assert (clip_count > 0) else begin
			errors++;
			$display("no negative sum reached the relu stage, clipping went untested");
		end
		assert (pass_count > 0) else begin
			errors++;
			$display("no positive sum reached the relu stage");
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the test sequence did not end within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+sim
logic/conv_pkg.sv
logic/window_buffer.sv
logic/weight_memory.sv
logic/bias_memory.sv
logic/conv_unit.sv
logic/conv_datapath.sv
sim/conv_datapath_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the convolution datapath testbench with Verilator and runs it.

TOP=conv_datapath_tb
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module "$TOP" -f vlog.f -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
